//--- MonoDisplay.f
+incdir+include
src/DisplayPkg.sv
src/FrameRam.sv
src/MemoryArbiter.sv
src/VgaScanout.sv
src/AxiLiteFramebufferPort.sv
src/MonoDisplay.sv
sim/MonoDisplayTb.sv

//--- Makefile
TOP := MonoDisplayTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f MonoDisplay.f -o $(TOP)

run: compile
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- sim/MonoDisplayTb.sv
// Testbench for the monochrome display: AXI traffic, shadow bitmap and screen checks
`timescale 1ns/1ps
`default_nettype none

module MonoDisplayTb;

	localparam int LineClocks    = 800;
	localparam int FrameLines    = 525;
	localparam int FrameClocks   = LineClocks * FrameLines;
	// Two frames plus the one-clock output lag
	localparam int RunCycles     = 2 * FrameClocks + 2;
	localparam int TimeoutCycles = 900000;
	localparam int WriteCount    = 40;
	localparam int HostLimit     = 8;

	logic        Clock;
	logic        Reset;
	logic [12:0] AWADDR_i;
	logic        AWVALID_i;
	logic        AWREADY_o;
	logic [31:0] WDATA_i;
	logic [3:0]  WSTRB_i;
	logic        WVALID_i;
	logic        WREADY_o;
	logic [1:0]  BRESP_o;
	logic        BVALID_o;
	logic        BREADY_i;
	logic [12:0] ARADDR_i;
	logic        ARVALID_i;
	logic        ARREADY_o;
	logic [31:0] RDATA_o;
	logic [1:0]  RRESP_o;
	logic        RVALID_o;
	logic        RREADY_i;
	logic        Red_o;
	logic        Green_o;
	logic        Blue_o;
	logic        HSync_o;
	logic        VSync_o;

	// Clocks since reset release
	int unsigned Count = 0;
	int unsigned TimeoutCounter = 0;
	int          ValueErrors = 0;
	int          OtherErrors = 0;
	logic [31:0] LfsrState;

	logic [7:0]  ShadowByte [0:2047];
	logic        ShadowValid [0:2047];
	logic [7:0]  ExpectedRead;
	int unsigned WrittenAddress [$];

	// Screen position one clock back
	int unsigned PrevIndex;
	int unsigned PrevX;
	int unsigned PrevY;
	int unsigned PrevFrame;
	int unsigned DotRow;
	logic [10:0] ByteAddress;
	logic        InActive;
	logic        ExpectPixel;
	logic        PixelKnown;
	logic        ExpectHSync;
	logic        ExpectVSync;
	logic [9:0]  ResetView;

	logic        HostPending = 1'b0;
	int unsigned HostWait = 0;
	logic        BHeld = 1'b0;
	logic        RHeld = 1'b0;
	logic [1:0]  LastBResp;
	logic [1:0]  LastRResp;
	logic [31:0] LastRData;

	MonoDisplay u_MonoDisplay (.*);

	always #2 Clock = !Clock;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] nextBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], LfsrState[0]};
			LfsrState = LfsrState[0] ? (LfsrState >> 1) ^ 32'h80200003 : LfsrState >> 1;
		end
		return value;
	endfunction

	task automatic reportValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		ValueErrors++;
		$display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
	endtask

	task automatic reportProblem(input string text);
		OtherErrors++;
		$display("Error at %0t ns: %s", $time, text);
	endtask

	always_comb begin
		PrevIndex   = Count - 1;
		PrevX       = PrevIndex % LineClocks;
		PrevY       = (PrevIndex / LineClocks) % FrameLines;
		PrevFrame   = PrevIndex / FrameClocks;
		InActive    = PrevX < 640 && PrevY < 480;
		ExpectHSync = !(PrevX >= 656 && PrevX < 752);
		ExpectVSync = !(PrevY >= 490 && PrevY < 492);
		// Page is dot row / 8, bit is dot row mod 8
		DotRow      = PrevY / 5;
		ByteAddress = 11'((DotRow / 8) * 128 + PrevX / 5);
		ExpectPixel = ShadowByte[ByteAddress][DotRow % 8];
		PixelKnown  = ShadowValid[ByteAddress];
	end

	assign ResetView = {HSync_o, VSync_o, Red_o, Green_o, Blue_o, BVALID_o, RVALID_o,
		AWREADY_o, WREADY_o, ARREADY_o};

	always @(posedge Clock) begin
		TimeoutCounter <= TimeoutCounter + 1;
		if (Reset) begin
			Count <= Count + 1;
		end
		BHeld     <= BVALID_o && !BREADY_i;
		RHeld     <= RVALID_o && !RREADY_i;
		LastBResp <= BRESP_o;
		LastRResp <= RRESP_o;
		LastRData <= RDATA_o;
		// Cycles from address handshake to response
		if ((AWVALID_i && AWREADY_o) || (ARVALID_i && ARREADY_o)) begin
			HostPending <= 1'b1;
			HostWait    <= 0;
		end else if (BVALID_o || RVALID_o) begin
			HostPending <= 1'b0;
		end else if (HostPending) begin
			HostWait <= HostWait + 1;
		end
		if (TimeoutCounter == TimeoutCycles) begin
			reportProblem("timeout, the run did not reach its end within the cycle limit");
			$display("ERRORS FOUND");
			$finish;
		end
	end

	resetValues: assert property (@(posedge Clock) disable iff (!Reset)
		Count == 0 |-> ResetView == 10'b1100000000)
		else reportValue("reset outputs", 32'h300, $sampled(ResetView));
	hSyncTiming: assert property (@(posedge Clock) disable iff (!Reset)
		Count > 0 |-> HSync_o == ExpectHSync)
		else reportValue("HSync_o", $sampled(ExpectHSync), $sampled(HSync_o));
	vSyncTiming: assert property (@(posedge Clock) disable iff (!Reset)
		Count > 0 |-> VSync_o == ExpectVSync)
		else reportValue("VSync_o", $sampled(ExpectVSync), $sampled(VSync_o));
	pixelMapping: assert property (@(posedge Clock) disable iff (!Reset)
		Count > 0 && PrevFrame == 1 && InActive && PixelKnown |-> Red_o == ExpectPixel)
		else reportValue("Red_o", $sampled(ExpectPixel), $sampled(Red_o));
	blanking: assert property (@(posedge Clock) disable iff (!Reset)
		Count > 0 && !InActive |-> {Red_o, Green_o, Blue_o} == 3'b000)
		else reportValue("Red_o,Green_o,Blue_o", 0, $sampled({Red_o, Green_o, Blue_o}));
	colourEqual: assert property (@(posedge Clock) disable iff (!Reset)
		Green_o === Red_o && Blue_o === Red_o)
		else reportValue("Green_o,Blue_o", $sampled({Red_o, Red_o}), $sampled({Green_o, Blue_o}));
	wReadyPaired: assert property (@(posedge Clock) disable iff (!Reset)
		WREADY_o == AWREADY_o)
		else reportValue("WREADY_o", $sampled(AWREADY_o), $sampled(WREADY_o));
	bRespOkay: assert property (@(posedge Clock) disable iff (!Reset)
		BVALID_o |-> BRESP_o == 2'b00)
		else reportValue("BRESP_o", 0, $sampled(BRESP_o));
	rRespOkay: assert property (@(posedge Clock) disable iff (!Reset)
		RVALID_o |-> RRESP_o == 2'b00)
		else reportValue("RRESP_o", 0, $sampled(RRESP_o));
	readBack: assert property (@(posedge Clock) disable iff (!Reset)
		RVALID_o |-> RDATA_o == {24'd0, ExpectedRead})
		else reportValue("RDATA_o", $sampled({24'd0, ExpectedRead}), $sampled(RDATA_o));
	bHold: assert property (@(posedge Clock) disable iff (!Reset)
		BHeld |-> BVALID_o && BRESP_o == LastBResp)
		else reportValue("BVALID_o,BRESP_o", $sampled({1'b1, LastBResp}),
			$sampled({BVALID_o, BRESP_o}));
	rHold: assert property (@(posedge Clock) disable iff (!Reset)
		RHeld |-> RVALID_o && RRESP_o == LastRResp)
		else reportValue("RVALID_o,RRESP_o", $sampled({1'b1, LastRResp}),
			$sampled({RVALID_o, RRESP_o}));
	rDataHold: assert property (@(posedge Clock) disable iff (!Reset)
		RHeld |-> RDATA_o == LastRData)
		else reportValue("RDATA_o", $sampled(LastRData), $sampled(RDATA_o));
	awRefused: assert property (@(posedge Clock) disable iff (!Reset)
		BVALID_o |-> !AWREADY_o)
		else reportValue("AWREADY_o", 0, $sampled(AWREADY_o));
	arRefused: assert property (@(posedge Clock) disable iff (!Reset)
		RVALID_o |-> !ARREADY_o)
		else reportValue("ARREADY_o", 0, $sampled(ARREADY_o));
	hostService: assert property (@(posedge Clock) disable iff (!Reset)
		HostPending |-> HostWait <= HostLimit)
		else reportProblem("stalled host access, no response within 8 cycles of the handshake");

	// Put one write on AW and W, called just after a rising edge
	task automatic presentWrite(input int unsigned address, input logic [7:0] data,
		input logic strobe);
		logic [31:0] noise;
		noise     = nextBits(2);
		AWADDR_i  = {address[10:0], noise[1:0]};
		noise     = nextBits(24);
		WDATA_i   = {noise[23:0], data};
		noise     = nextBits(3);
		WSTRB_i   = {noise[2:0], strobe};
		AWVALID_i = 1'b1;
		WVALID_i  = 1'b1;
	endtask

	task automatic awaitWriteAccept();
		@(negedge Clock);
		while (!AWREADY_o) @(negedge Clock);
		@(posedge Clock);
		#0.5;
		AWVALID_i = 1'b0;
		WVALID_i  = 1'b0;
	endtask

	// Back-pressure for a random number of cycles
	task automatic takeWriteResponse();
		int unsigned holdCycles;
		holdCycles = nextBits(2);
		while (!BVALID_o) @(negedge Clock);
		repeat (holdCycles) @(posedge Clock);
		@(posedge Clock);
		#0.5 BREADY_i = 1'b1;
		@(posedge Clock);
		#0.5 BREADY_i = 1'b0;
	endtask

	task automatic writeByte(input int unsigned address, input logic [7:0] data,
		input logic strobe);
		@(posedge Clock);
		#0.5;
		presentWrite(address, data, strobe);
		awaitWriteAccept();
		if (strobe) begin
			ShadowByte[address]  = data;
			ShadowValid[address] = 1'b1;
			WrittenAddress.push_back(address);
		end
		// Same write offered again while the first response is held back
		while (!BVALID_o) @(negedge Clock);
		@(posedge Clock);
		#0.5;
		presentWrite(address, data, strobe);
		takeWriteResponse();
		awaitWriteAccept();
		takeWriteResponse();
	endtask

	task automatic presentRead(input int unsigned address);
		logic [31:0] noise;
		noise     = nextBits(2);
		ARADDR_i  = {address[10:0], noise[1:0]};
		ARVALID_i = 1'b1;
	endtask

	task automatic awaitReadAccept();
		@(negedge Clock);
		while (!ARREADY_o) @(negedge Clock);
		@(posedge Clock);
		#0.5 ARVALID_i = 1'b0;
	endtask

	task automatic takeReadResponse();
		int unsigned holdCycles;
		holdCycles = nextBits(2);
		while (!RVALID_o) @(negedge Clock);
		repeat (holdCycles) @(posedge Clock);
		@(posedge Clock);
		#0.5 RREADY_i = 1'b1;
		@(posedge Clock);
		#0.5 RREADY_i = 1'b0;
	endtask

	task automatic readByte(input int unsigned address);
		ExpectedRead = ShadowByte[address];
		@(posedge Clock);
		#0.5;
		presentRead(address);
		awaitReadAccept();
		// Second read of the same byte waits behind the held read data
		while (!RVALID_o) @(negedge Clock);
		@(posedge Clock);
		#0.5;
		presentRead(address);
		takeReadResponse();
		awaitReadAccept();
		takeReadResponse();
	endtask

	initial begin
		int unsigned address;
		logic [7:0]  data;
		logic        strobe;
		LfsrState = 32'd32235;
		Clock     = 1'b0;
		Reset     = 1'b0;
		AWADDR_i  = '0;
		AWVALID_i = 1'b0;
		WDATA_i   = '0;
		WSTRB_i   = '0;
		WVALID_i  = 1'b0;
		BREADY_i  = 1'b0;
		ARADDR_i  = '0;
		ARVALID_i = 1'b0;
		RREADY_i  = 1'b0;
		ExpectedRead = '0;
		for (int i = 0; i < 2048; i++) begin
			ShadowByte[i]  = '0;
			ShadowValid[i] = 1'b0;
		end
		repeat (8) @(posedge Clock);
		#0.5 Reset = 1'b1;
		for (int n = 0; n < WriteCount; n++) begin
			// Roughly one write in four hits an old byte with the strobe clear
			if (WrittenAddress.size() > 0 && nextBits(2) == 0) begin
				address = WrittenAddress[nextBits(8) % WrittenAddress.size()];
				strobe  = 1'b0;
			end else begin
				address = nextBits(11);
				strobe  = 1'b1;
			end
			data = nextBits(8);
			writeByte(address, data, strobe);
			readByte(address);
		end
		while (Count < RunCycles) @(posedge Clock);
		@(negedge Clock);
		$display("Checks done: %0d value errors, %0d other errors", ValueErrors, OtherErrors);
		if (ValueErrors == 0 && OtherErrors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/MonoDisplay.sv
// Monochrome display top: scanout, AXI host port, arbiter and frame memory
`timescale 1ns/1ps
`default_nettype none

module MonoDisplay (
	input  wire         Clock,
	input  wire         Reset,
	input  wire  [12:0] AWADDR_i,
	input  wire         AWVALID_i,
	output logic        AWREADY_o,
	input  wire  [31:0] WDATA_i,
	input  wire  [3:0]  WSTRB_i,
	input  wire         WVALID_i,
	output logic        WREADY_o,
	output logic [1:0]  BRESP_o,
	output logic        BVALID_o,
	input  wire         BREADY_i,
	input  wire  [12:0] ARADDR_i,
	input  wire         ARVALID_i,
	output logic        ARREADY_o,
	output logic [31:0] RDATA_o,
	output logic [1:0]  RRESP_o,
	output logic        RVALID_o,
	input  wire         RREADY_i,
	output logic        Red_o,
	output logic        Green_o,
	output logic        Blue_o,
	output logic        HSync_o,
	output logic        VSync_o
);

	logic                 ScanRequest;
	DisplayPkg::ramAddr_t ScanAddress;
	logic                 ScanGrant;
	logic                 HostRequest;
	DisplayPkg::ramAddr_t HostAddress;
	logic                 HostWrite;
	DisplayPkg::ramData_t HostWriteData;
	logic                 HostGrant;
	DisplayPkg::ramAddr_t RamAddress;
	logic                 RamWriteEnable;
	DisplayPkg::ramData_t RamWriteData;
	// Shared by both peers
	DisplayPkg::ramData_t RamReadData;

	VgaScanout u_VgaScanout (
		.Clock(Clock), .Reset(Reset),
		.FetchRequest_o(ScanRequest), .FetchAddress_o(ScanAddress),
		.FetchGrant_i(ScanGrant), .FetchData_i(RamReadData),
		.Red_o(Red_o), .Green_o(Green_o), .Blue_o(Blue_o),
		.HSync_o(HSync_o), .VSync_o(VSync_o)
	);

	AxiLiteFramebufferPort u_AxiLiteFramebufferPort (
		.Clock(Clock), .Reset(Reset),
		.AWADDR_i(AWADDR_i), .AWVALID_i(AWVALID_i), .AWREADY_o(AWREADY_o),
		.WDATA_i(WDATA_i), .WSTRB_i(WSTRB_i), .WVALID_i(WVALID_i), .WREADY_o(WREADY_o),
		.BRESP_o(BRESP_o), .BVALID_o(BVALID_o), .BREADY_i(BREADY_i),
		.ARADDR_i(ARADDR_i), .ARVALID_i(ARVALID_i), .ARREADY_o(ARREADY_o),
		.RDATA_o(RDATA_o), .RRESP_o(RRESP_o), .RVALID_o(RVALID_o), .RREADY_i(RREADY_i),
		.MemRequest_o(HostRequest), .MemAddress_o(HostAddress), .MemWrite_o(HostWrite),
		.MemWriteData_o(HostWriteData), .MemGrant_i(HostGrant),
		.MemReadData_i(RamReadData)
	);

	MemoryArbiter u_MemoryArbiter (
		.Clock(Clock), .Reset(Reset),
		.ScanRequest_i(ScanRequest), .ScanAddress_i(ScanAddress),
		.HostRequest_i(HostRequest), .HostAddress_i(HostAddress),
		.HostWrite_i(HostWrite), .HostWriteData_i(HostWriteData),
		.ScanGrant_o(ScanGrant), .HostGrant_o(HostGrant),
		.RamAddress_o(RamAddress), .RamWriteEnable_o(RamWriteEnable),
		.RamWriteData_o(RamWriteData)
	);

	FrameRam u_FrameRam (
		.Clock(Clock), .Address_i(RamAddress), .WriteEnable_i(RamWriteEnable),
		.WriteData_i(RamWriteData), .ReadData_o(RamReadData)
	);

endmodule

`default_nettype wire

//--- src/AxiLiteFramebufferPort.sv
// AXI4-Lite slave giving the host byte access to the frame memory
`timescale 1ns/1ps
`default_nettype none

module AxiLiteFramebufferPort (
	input  wire                  Clock,
	input  wire                  Reset,
	input  wire  [12:0]          AWADDR_i,
	input  wire                  AWVALID_i,
	output logic                 AWREADY_o,
	input  wire  [31:0]          WDATA_i,
	input  wire  [3:0]           WSTRB_i,
	input  wire                  WVALID_i,
	output logic                 WREADY_o,
	output logic [1:0]           BRESP_o,
	output logic                 BVALID_o,
	input  wire                  BREADY_i,
	input  wire  [12:0]          ARADDR_i,
	input  wire                  ARVALID_i,
	output logic                 ARREADY_o,
	output logic [31:0]          RDATA_o,
	output logic [1:0]           RRESP_o,
	output logic                 RVALID_o,
	input  wire                  RREADY_i,
	output logic                 MemRequest_o,
	output DisplayPkg::ramAddr_t MemAddress_o,
	output logic                 MemWrite_o,
	output DisplayPkg::ramData_t MemWriteData_o,
	input  wire                  MemGrant_i,
	input  DisplayPkg::ramData_t MemReadData_i
);

	typedef enum logic [2:0] {
		idle          = 3'd0,
		writeWait     = 3'd1,
		readWait      = 3'd2,
		readCapture   = 3'd3,
		writeResponse = 3'd4,
		readResponse  = 3'd5
	} portState_t;

	portState_t           State;
	logic                 WriteAccept;
	logic                 ReadAccept;
	DisplayPkg::ramAddr_t Address;
	DisplayPkg::ramData_t WriteByte;
	logic                 WriteStrobe;
	DisplayPkg::ramData_t ReadByte;

	// Write wins when both arrive, AW and W only as a pair
	assign WriteAccept = State == idle && AWVALID_i && WVALID_i;
	assign ReadAccept  = State == idle && ARVALID_i && !(AWVALID_i && WVALID_i);

	assign AWREADY_o = WriteAccept;
	assign WREADY_o  = WriteAccept;
	assign ARREADY_o = ReadAccept;

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			State <= idle;
		end else begin
			case (State)
				idle: begin
					if (WriteAccept) begin
						State <= writeWait;
					end else if (ReadAccept) begin
						State <= readWait;
					end
				end
				writeWait:     if (MemGrant_i) State <= writeResponse;
				readWait:      if (MemGrant_i) State <= readCapture;
				readCapture:   State <= readResponse;
				writeResponse: if (BREADY_i) State <= idle;
				readResponse:  if (RREADY_i) State <= idle;
				default:       State <= idle;
			endcase
		end
	end

	// Byte address is the AXI word address
	always_ff @(posedge Clock) begin
		if (WriteAccept) begin
			Address     <= AWADDR_i[12:2];
			WriteByte   <= WDATA_i[7:0];
			WriteStrobe <= WSTRB_i[0];
		end else if (ReadAccept) begin
			Address <= ARADDR_i[12:2];
		end
		if (State == readCapture) begin
			ReadByte <= MemReadData_i;
		end
	end

	// A write with a clear strobe still takes a slot but stores nothing
	assign MemRequest_o   = State == writeWait || State == readWait;
	assign MemAddress_o   = Address;
	assign MemWrite_o     = State == writeWait && WriteStrobe;
	assign MemWriteData_o = WriteByte;

	assign BVALID_o = State == writeResponse;
	assign RVALID_o = State == readResponse;
	assign BRESP_o  = 2'b00;
	assign RRESP_o  = 2'b00;
	assign RDATA_o  = {24'd0, ReadByte};

endmodule

`default_nettype wire

//--- src/VgaScanout.sv
// VGA scanout: 640x480 timing, 5x5 dot scaling, byte prefetch and registered outputs
`timescale 1ns/1ps
`default_nettype none
`include "display_consts.svh"

module VgaScanout (
	input  wire                  Clock,
	input  wire                  Reset,
	output logic                 FetchRequest_o,
	output DisplayPkg::ramAddr_t FetchAddress_o,
	input  wire                  FetchGrant_i,
	input  DisplayPkg::ramData_t FetchData_i,
	output logic                 Red_o,
	output logic                 Green_o,
	output logic                 Blue_o,
	output logic                 HSync_o,
	output logic                 VSync_o
);

	typedef enum logic [1:0] {
		active     = 2'd0,
		frontPorch = 2'd1,
		syncPulse  = 2'd2,
		backPorch  = 2'd3
	} phase_t;

	logic [9:0] HCounter;
	logic [9:0] VCounter;
	phase_t     HState;
	phase_t     VState;
	logic       LineEnd;

	// Dot counters, HColumn runs 0..159 over the full line
	logic [2:0] HDivider;
	logic [7:0] HColumn;
	logic [2:0] VDivider;
	logic [6:0] Row;

	logic                 LastColumn;
	logic                 NextLineActive;
	logic [6:0]           NextRow;
	logic [6:0]           FetchColumn;
	logic [6:0]           FetchRow;
	logic                 FetchPending;
	DisplayPkg::ramData_t NextByte;
	DisplayPkg::ramData_t ColumnByte;
	logic                 Pixel;

	assign LineEnd = HCounter == `H_TOTAL - 1;

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			HCounter <= '0;
			VCounter <= '0;
		end else if (LineEnd) begin
			HCounter <= '0;
			VCounter <= (VCounter == `V_TOTAL - 1) ? 10'd0 : VCounter + 10'd1;
		end else begin
			HCounter <= HCounter + 10'd1;
		end
	end

	// State follows the counter, so HState is the phase of HCounter
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			HState <= active;
		end else begin
			case (HState)
				active:     if (HCounter == `H_ACTIVE - 1) HState <= frontPorch;
				frontPorch: if (HCounter == `H_FRONT_END - 1) HState <= syncPulse;
				syncPulse:  if (HCounter == `H_SYNC_END - 1) HState <= backPorch;
				backPorch:  if (LineEnd) HState <= active;
				default:    HState <= active;
			endcase
		end
	end

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			VState <= active;
		end else if (LineEnd) begin
			case (VState)
				active:     if (VCounter == `V_ACTIVE - 1) VState <= frontPorch;
				frontPorch: if (VCounter == `V_FRONT_END - 1) VState <= syncPulse;
				syncPulse:  if (VCounter == `V_SYNC_END - 1) VState <= backPorch;
				backPorch:  if (VCounter == `V_TOTAL - 1) VState <= active;
				default:    VState <= active;
			endcase
		end
	end

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			HDivider <= '0;
			HColumn  <= '0;
			VDivider <= '0;
			Row      <= '0;
		end else begin
			if (LineEnd) begin
				HDivider <= '0;
				HColumn  <= '0;
				VDivider <= (VDivider == `DOT_SCALE - 1 || VCounter == `V_TOTAL - 1) ?
					3'd0 : VDivider + 3'd1;
				Row      <= NextRow;
			end else if (HDivider == `DOT_SCALE - 1) begin
				HDivider <= '0;
				HColumn  <= HColumn + 8'd1;
			end else begin
				HDivider <= HDivider + 3'd1;
			end
		end
	end

	// Dot row of the line after this one
	assign NextRow = (VCounter == `V_TOTAL - 1) ? 7'd0 :
		(VDivider == `DOT_SCALE - 1) ? Row + 7'd1 : Row;

	// Column 159 sits in blanking, its fetch is column 0 of the next line
	assign LastColumn     = HColumn == `H_TOTAL / `DOT_SCALE - 1;
	assign NextLineActive = VCounter == `V_TOTAL - 1 || VCounter < `V_ACTIVE - 1;
	assign FetchColumn    = LastColumn ? 7'd0 : HColumn[6:0] + 7'd1;
	assign FetchRow       = LastColumn ? NextRow : Row;

	// Third clock of each dot
	assign FetchRequest_o = HDivider == 3'd2 &&
		((VState == active && HColumn < `BITMAP_COLUMNS - 1) ||
		(LastColumn && NextLineActive));
	assign FetchAddress_o = {FetchRow[6:3], FetchColumn};

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			FetchPending <= 1'b0;
		end else begin
			FetchPending <= FetchGrant_i;
		end
	end

	always_ff @(posedge Clock) begin
		if (FetchPending) begin
			NextByte <= FetchData_i;
		end
		// Swap in the prefetched byte at the column boundary
		if (HDivider == `DOT_SCALE - 1) begin
			ColumnByte <= NextByte;
		end
	end

	assign Pixel = HState == active && VState == active && ColumnByte[Row[2:0]];

	// Outputs lag the position by one clock
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			Red_o   <= 1'b0;
			Green_o <= 1'b0;
			Blue_o  <= 1'b0;
			HSync_o <= 1'b1;
			VSync_o <= 1'b1;
		end else begin
			Red_o   <= Pixel;
			Green_o <= Pixel;
			Blue_o  <= Pixel;
			HSync_o <= HState != syncPulse;
			VSync_o <= VState != syncPulse;
		end
	end

endmodule

`default_nettype wire

//--- src/MemoryArbiter.sv
// Memory arbiter: fixed priority, scanout over host, for the single-port frame memory
`timescale 1ns/1ps
`default_nettype none

module MemoryArbiter (
	input  wire                  Clock,
	input  wire                  Reset,
	input  wire                  ScanRequest_i,
	input  DisplayPkg::ramAddr_t ScanAddress_i,
	input  wire                  HostRequest_i,
	input  DisplayPkg::ramAddr_t HostAddress_i,
	input  wire                  HostWrite_i,
	input  DisplayPkg::ramData_t HostWriteData_i,
	output logic                 ScanGrant_o,
	output logic                 HostGrant_o,
	output DisplayPkg::ramAddr_t RamAddress_o,
	output logic                 RamWriteEnable_o,
	output DisplayPkg::ramData_t RamWriteData_o
);

	// Owner of the read data that FrameRam returns this cycle
	DisplayPkg::requester_t LastGrant;

	// Scanout pulse always wins, host waits at most one cycle
	assign ScanGrant_o = ScanRequest_i;
	assign HostGrant_o = HostRequest_i && !ScanRequest_i;

	always_comb begin
		if (ScanRequest_i) begin
			RamAddress_o = ScanAddress_i;
		end else if (HostRequest_i) begin
			RamAddress_o = HostAddress_i;
		end else if (LastGrant == DisplayPkg::scanout) begin
			// Idle, keep the last winner's address on the RAM
			RamAddress_o = ScanAddress_i;
		end else begin
			RamAddress_o = HostAddress_i;
		end
	end

	// Only the host ever writes
	assign RamWriteEnable_o = HostGrant_o && HostWrite_i;
	assign RamWriteData_o   = HostWriteData_i;

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			LastGrant <= DisplayPkg::scanout;
		end else if (ScanRequest_i) begin
			LastGrant <= DisplayPkg::scanout;
		end else if (HostRequest_i) begin
			LastGrant <= DisplayPkg::host;
		end
	end

endmodule

`default_nettype wire

//--- src/FrameRam.sv
// Frame memory: 2048 by 8 single-port RAM with one-cycle synchronous read
`timescale 1ns/1ps
`default_nettype none

module FrameRam (
	input  wire                  Clock,
	input  DisplayPkg::ramAddr_t Address_i,
	input  wire                  WriteEnable_i,
	input  DisplayPkg::ramData_t WriteData_i,
	output DisplayPkg::ramData_t ReadData_o
);

	DisplayPkg::ramData_t Memory [0:2047];

	// Read returns the old byte when the same address is written
	always_ff @(posedge Clock) begin
		if (WriteEnable_i) begin
			Memory[Address_i] <= WriteData_i;
		end
		ReadData_o <= Memory[Address_i];
	end

endmodule

`default_nettype wire

//--- src/DisplayPkg.sv
// Display package: frame memory address, data and requester types
package DisplayPkg;

	// Byte address, page number in [10:7] and column in [6:0]
	typedef logic [10:0] ramAddr_t;

	// One column of one page, bit n is dot row n of the page
	typedef logic [7:0] ramData_t;

	// Peer that owns the frame memory in a given cycle
	typedef enum logic {
		scanout = 1'b0,
		host    = 1'b1
	} requester_t;

endpackage

//--- include/display_consts.svh
// Display constants: VGA 640x480 timing limits, dot scale and bitmap geometry
`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

// Horizontal timing in pixel clocks, each value is the first clock past its interval
`define H_ACTIVE 10'd640
`define H_FRONT_END 10'd656
`define H_SYNC_END 10'd752
`define H_TOTAL 10'd800

// Vertical timing in lines
`define V_ACTIVE 10'd480
`define V_FRONT_END 10'd490
`define V_SYNC_END 10'd492
`define V_TOTAL 10'd525

// Screen pixels per bitmap dot, both directions
`define DOT_SCALE 10'd5

// Bitmap size in dots
`define BITMAP_COLUMNS 10'd128
`define BITMAP_ROWS 10'd96

// 16 pages of 128 column bytes
`define FRAME_BYTES 12'd2048

`endif
